// File: src/aes_pkg.sv
// ----------------------------------------------------------
// aes encipher shared types
// ----------------------------------------------------------
package aes_pkg;

  // widths with a meaning in the datapath
  typedef logic [7:0]   byte_t;
  typedef logic [31:0]  word_t;
  typedef logic [127:0] block_t;
  typedef logic [3:0]   round_t;
  typedef logic [1:0]   sword_t;

  // key length select, sampled by the controller
  typedef enum logic {
    KEY_128,
    KEY_256
  } keylen_e;

  // round counts per key length
  localparam round_t AES128_ROUNDS = 4'd10;
  localparam round_t AES256_ROUNDS = 4'd14;

  // kind of state update requested from the datapath
  typedef enum logic [2:0] {
    UPD_NONE,
    UPD_INIT,
    UPD_SBOX,
    UPD_MAIN,
    UPD_FINAL
  } update_e;

  // controller states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_INIT,
    CTRL_SBOX,
    CTRL_MAIN,
    CTRL_FINAL
  } ctrl_state_e;

  // controller to datapath command
  typedef struct packed {
    update_e upd;
    sword_t  sword;
  } round_cmd_t;

  // ----------------------------------------------------------
  // gf(2^8) helpers for mixcolumns
  // ----------------------------------------------------------

  // multiply by x, reduce with the aes polynomial 0x11b
  function automatic byte_t gm2(input byte_t op);
    return {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  // multiply by x + 1
  function automatic byte_t gm3(input byte_t op);
    return gm2(op) ^ op;
  endfunction

endpackage

// File: src/aes_sbox.sv
// ----------------------------------------------------------
// aes forward s-box, one word
// ----------------------------------------------------------
`timescale 1ns/1ps

module aes_sbox (
  input  aes_pkg::word_t sboxw,
  output aes_pkg::word_t new_sboxw
);
  import aes_pkg::*;

  // forward s-box lookup
  // high nibble picks a row of 16 entries, low nibble picks the byte in it
  // entry 0 of each row sits in the top byte of the row constant
  function automatic byte_t sub_byte(input byte_t b);
    logic [127:0] row;
    case (b[7:4])
      4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
      4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
      4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
      4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
      4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
      4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
      4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
      4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
      4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
      4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
      4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
      4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
      4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
      4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
      4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
      default: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
    endcase
    return row[8 * (4'd15 - b[3:0]) +: 8];
  endfunction

  // ----------------------------------------------------------
  // four parallel lookups
  // ----------------------------------------------------------

  // row 0 byte of the column
  assign new_sboxw[31:24] = sub_byte(sboxw[31:24]);

  // row 1 byte
  assign new_sboxw[23:16] = sub_byte(sboxw[23:16]);

  // row 2 byte
  assign new_sboxw[15:8]  = sub_byte(sboxw[15:8]);

  // row 3 byte
  assign new_sboxw[7:0]   = sub_byte(sboxw[7:0]);

endmodule

// File: src/aes_round_ctrl.sv
// ----------------------------------------------------------
// aes round controller
// ----------------------------------------------------------
`timescale 1ns/1ps

module aes_round_ctrl (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                next,
  input  aes_pkg::keylen_e    keylen,
  output aes_pkg::round_cmd_t cmd,
  output aes_pkg::round_t     round,
  output logic                ready
);
  import aes_pkg::*;

  ctrl_state_e state_reg;
  round_t      round_reg;
  sword_t      sword_reg;
  logic        ready_reg;

  round_t      num_rounds;
  logic        last_round;

  // round count follows the key length
  assign num_rounds = (keylen == KEY_256) ? AES256_ROUNDS : AES128_ROUNDS;
  assign last_round = (round_reg == num_rounds);

  assign round = round_reg;
  assign ready = ready_reg;

  // ----------------------------------------------------------
  // fsm with round and word counters
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= CTRL_IDLE;
      round_reg <= '0;
      sword_reg <= '0;
      ready_reg <= 1'b1;
    end
    else
    begin
      case (state_reg)
        // wait for a start pulse, round 0 selects the whitening key
        CTRL_IDLE:
          if (next)
          begin
            round_reg <= '0;
            ready_reg <= 1'b0;
            state_reg <= CTRL_INIT;
          end
        // initial key add happens here
        CTRL_INIT:
        begin
          round_reg <= round_reg + 4'd1;
          sword_reg <= '0;
          state_reg <= CTRL_SBOX;
        end
        // one word per cycle, then the round transform
        CTRL_SBOX:
        begin
          sword_reg <= sword_reg + 2'd1;
          if (sword_reg == 2'd3)
            state_reg <= last_round ? CTRL_FINAL : CTRL_MAIN;
        end
        // word counter has wrapped to 0 already
        CTRL_MAIN:
        begin
          round_reg <= round_reg + 4'd1;
          state_reg <= CTRL_SBOX;
        end
        // result is captured by the datapath on this edge
        CTRL_FINAL:
        begin
          ready_reg <= 1'b1;
          state_reg <= CTRL_IDLE;
        end
        default:
          state_reg <= CTRL_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // command decode
  // ----------------------------------------------------------
  always_comb
  begin
    cmd.sword = sword_reg;
    case (state_reg)
      CTRL_INIT:  cmd.upd = UPD_INIT;
      CTRL_SBOX:  cmd.upd = UPD_SBOX;
      CTRL_MAIN:  cmd.upd = UPD_MAIN;
      CTRL_FINAL: cmd.upd = UPD_FINAL;
      default:    cmd.upd = UPD_NONE;
    endcase
  end

endmodule

// File: src/aes_state_datapath.sv
// ----------------------------------------------------------
// aes state datapath
// ----------------------------------------------------------
`timescale 1ns/1ps

module aes_state_datapath (
  input  logic                clk,
  input  logic                reset_n,
  input  aes_pkg::round_cmd_t cmd,
  input  aes_pkg::block_t     block,
  input  aes_pkg::block_t     round_key,
  input  aes_pkg::word_t      new_sboxw,
  output aes_pkg::word_t      sboxw,
  output aes_pkg::block_t     new_block
);
  import aes_pkg::*;

  // state columns, word 0 is the top of the block
  word_t w_reg [4];

  // shifted and mixed columns
  word_t sr_w  [4];
  word_t mc_w  [4];
  word_t key_w [4];
  word_t blk_w [4];

  // mixcolumns on one column {a0, a1, a2, a3}, a0 in the top byte
  function automatic word_t mix_column(input word_t col);
    byte_t a0;
    byte_t a1;
    byte_t a2;
    byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {gm2(a0) ^ gm3(a1) ^ a2 ^ a3,
            a0 ^ gm2(a1) ^ gm3(a2) ^ a3,
            a0 ^ a1 ^ gm2(a2) ^ gm3(a3),
            gm3(a0) ^ a1 ^ a2 ^ gm2(a3)};
  endfunction

  // ----------------------------------------------------------
  // round transform
  // ----------------------------------------------------------
  always_comb
  begin
    // shiftrows, row r of column c comes from column c + r
    sr_w[0] = {w_reg[0][31:24], w_reg[1][23:16], w_reg[2][15:8], w_reg[3][7:0]};
    sr_w[1] = {w_reg[1][31:24], w_reg[2][23:16], w_reg[3][15:8], w_reg[0][7:0]};
    sr_w[2] = {w_reg[2][31:24], w_reg[3][23:16], w_reg[0][15:8], w_reg[1][7:0]};
    sr_w[3] = {w_reg[3][31:24], w_reg[0][23:16], w_reg[1][15:8], w_reg[2][7:0]};
    for (int i = 0; i < 4; i++)
    begin
      mc_w[i]  = mix_column(sr_w[i]);
      key_w[i] = round_key[127 - 32 * i -: 32];
      blk_w[i] = block[127 - 32 * i -: 32];
    end
  end

  // word selected for substitution
  assign sboxw = w_reg[cmd.sword];

  // state update per command
  always_ff @(posedge clk)
  begin
    case (cmd.upd)
      UPD_INIT:
        for (int i = 0; i < 4; i++)
          w_reg[i] <= blk_w[i] ^ key_w[i];
      UPD_SBOX:
        w_reg[cmd.sword] <= new_sboxw;
      UPD_MAIN:
        for (int i = 0; i < 4; i++)
          w_reg[i] <= mc_w[i] ^ key_w[i];
      default:
        ;
    endcase
  end

  // final round skips mixcolumns and goes straight to the output
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      new_block <= '0;
    else if (cmd.upd == UPD_FINAL)
      new_block <= {sr_w[0], sr_w[1], sr_w[2], sr_w[3]} ^ round_key;
  end

endmodule

// File: src/aes_encipher_block.sv
// ----------------------------------------------------------
// aes encipher engine
// ----------------------------------------------------------
`timescale 1ns/1ps

module aes_encipher_block (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             next,
  input  aes_pkg::keylen_e keylen,
  input  aes_pkg::block_t  block,
  input  aes_pkg::block_t  round_key,
  output aes_pkg::round_t  round,
  output aes_pkg::block_t  new_block,
  output logic             ready
);
  import aes_pkg::*;

  // controller command and shared s-box path
  round_cmd_t cmd;
  word_t      sboxw;
  word_t      new_sboxw;

  // sequencing, round index and ready
  aes_round_ctrl i_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .next    (next),
    .keylen  (keylen),
    .cmd     (cmd),
    .round   (round),
    .ready   (ready)
  );

  // state words and round math
  aes_state_datapath i_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd       (cmd),
    .block     (block),
    .round_key (round_key),
    .new_sboxw (new_sboxw),
    .sboxw     (sboxw),
    .new_block (new_block)
  );

  // one word substituted per cycle
  aes_sbox i_sbox (
    .sboxw     (sboxw),
    .new_sboxw (new_sboxw)
  );

endmodule

// File: bench/tb_clock_gen.sv
// ----------------------------------------------------------
// testbench clock and reset
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held low over 8 rising edges, released on a falling edge
  initial
  begin
    reset_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

// File: bench/aes_encipher_chk.sv
// ----------------------------------------------------------
// aes encipher protocol checks
// ----------------------------------------------------------
`timescale 1ns/1ps

module aes_encipher_chk (
  input logic                clk,
  input logic                reset_n,
  input logic                next,
  input logic                ready,
  input aes_pkg::keylen_e    keylen,
  input aes_pkg::round_t     round,
  input aes_pkg::round_cmd_t cmd
);
  import aes_pkg::*;

  // cycles spent with ready low, and the round count of the run
  logic [7:0] low_cnt;
  round_t     run_rounds;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      low_cnt    <= '0;
      run_rounds <= '0;
    end
    else
    begin
      if (next && ready)
        run_rounds <= (keylen == KEY_256) ? 4'd14 : 4'd10;
      low_cnt <= ready ? 8'd0 : low_cnt + 8'd1;
    end
  end

  // an accepted start drops ready on the next edge
  a_ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
    (next && ready) |=> !ready)
    else $error("ready still high one cycle after an accepted start");

  // no round index beyond the 256-bit key count
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
    round <= 4'd14)
    else $error("round index above 14");

  // busy window is 1 + 5N cycles
  a_latency: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(ready) |-> (low_cnt == 8'd1 + 8'd5 * {4'd0, run_rounds}))
    else $error("ready low for the wrong number of cycles");

  // substitution only while busy
  a_sbox_busy: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> (cmd.upd != UPD_SBOX))
    else $error("sbox command issued while ready");

endmodule

bind aes_encipher_block aes_encipher_chk i_chk (
  .clk     (clk),
  .reset_n (reset_n),
  .next    (next),
  .ready   (ready),
  .keylen  (keylen),
  .round   (round),
  .cmd     (cmd)
);

// File: bench/tb_aes_encipher.sv
// ----------------------------------------------------------
// aes encipher testbench
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_aes_encipher;
  import aes_pkg::*;

  localparam int NR_128 = 10;
  localparam int NR_256 = 14;
  // 20 blocks of up to 80 cycles, plus margin
  localparam int TIMEOUT_CYCLES = 20 * 80 + 400;

  logic     clk;
  logic     reset_n;
  logic     next;
  keylen_e  keylen;
  block_t   block;
  block_t   round_key;
  round_t   round;
  block_t   new_block;
  logic     ready;

  block_t      key_tbl [0:14];
  byte_t       sbox_tbl [256];
  logic [31:0] lcg_state;
  block_t      exp_q [$];
  int          nr_q [$];
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          low_cnt = 0;
  logic        ready_q = 1'b1;

  tb_clock_gen i_clk_gen (.clk(clk), .reset_n(reset_n));

  aes_encipher_block i_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // shift and add multiply in gf(2^8)
  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t p;
    byte_t x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ x;
      x = xtime(x);
    end
    return p;
  endfunction

  // s-box from the multiplicative inverse and the affine map
  task automatic build_sbox();
    byte_t inv;
    for (int x = 0; x < 256; x++)
    begin
      inv = 8'h00;
      for (int y = 1; y < 256; y++)
        if (gf_mul(8'(x), 8'(y)) == 8'h01)
          inv = 8'(y);
      sbox_tbl[x] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                    ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    end
  endtask

  // byte i of the block sits at bits 127-8i, column-major
  function automatic block_t aes_ref(input block_t pt, input int nr);
    byte_t  st [16];
    byte_t  sh [16];
    byte_t  a0;
    byte_t  a1;
    byte_t  a2;
    byte_t  a3;
    block_t acc;
    acc = pt ^ key_tbl[0];
    for (int r = 1; r <= nr; r++)
    begin
      for (int i = 0; i < 16; i++)
        st[i] = sbox_tbl[acc[127 - 8 * i -: 8]];
      // row rw of column c taken from column c + rw
      for (int c = 0; c < 4; c++)
        for (int rw = 0; rw < 4; rw++)
          sh[4 * c + rw] = st[4 * ((c + rw) % 4) + rw];
      // mixcolumns except in the last round
      if (r < nr)
        for (int c = 0; c < 4; c++)
        begin
          a0 = sh[4 * c];
          a1 = sh[4 * c + 1];
          a2 = sh[4 * c + 2];
          a3 = sh[4 * c + 3];
          sh[4 * c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
          sh[4 * c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
          sh[4 * c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
          sh[4 * c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
      for (int i = 0; i < 16; i++)
        acc[127 - 8 * i -: 8] = sh[i];
      acc = acc ^ key_tbl[r];
    end
    return acc;
  endfunction

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic rand_block(output block_t b);
    for (int i = 0; i < 4; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      b[127 - 32 * i -: 32] = lcg_state;
    end
  endtask

  // start one block, optionally with a second pulse while busy
  task automatic start_block(input keylen_e kl, input block_t b, input bit busy);
    block_t other;
    int     nr;
    nr = (kl == KEY_256) ? NR_256 : NR_128;
    while (!ready)
      @(negedge clk);
    keylen = kl;
    block  = b;
    next   = 1'b1;
    exp_q.push_back(aes_ref(b, nr));
    nr_q.push_back(nr);
    @(negedge clk);
    next = 1'b0;
    checks++;
    if (ready !== 1'b0)
    begin
      errors++;
      $display("Mismatch at %0t: ready %b one cycle after start, expected 0", $time, ready);
    end
    if (busy)
    begin
      repeat (12) @(negedge clk);
      rand_block(other);
      block = other;
      next  = 1'b1;
      @(negedge clk);
      next = 1'b0;
    end
    while (!ready)
      @(negedge clk);
    @(negedge clk);
  endtask

  // round key answers the current round index
  always @(negedge clk)
    round_key = (round <= 4'd14) ? key_tbl[round] : '0;

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial
  begin
    block_t b;
    next      = 1'b0;
    keylen    = KEY_128;
    block     = '0;
    round_key = '0;
    lcg_state = 32'd37;
    build_sbox();
    for (int i = 0; i < 15; i++)
      rand_block(key_tbl[i]);

    @(posedge reset_n);
    @(negedge clk);
    // reset state
    checks++;
    if (ready !== 1'b1 || round !== 4'd0 || new_block !== '0)
    begin
      errors++;
      $display("Mismatch at %0t: after reset ready %b round %0d new_block %h", $time,
               ready, round, new_block);
    end

    for (int i = 0; i < 8; i++)
    begin
      rand_block(b);
      start_block(KEY_128, b, 1'b0);
    end
    for (int i = 0; i < 8; i++)
    begin
      rand_block(b);
      start_block(KEY_256, b, 1'b0);
    end
    // second pulse mid-run must be ignored
    rand_block(b);
    start_block(KEY_256, b, 1'b1);

    repeat (3) @(negedge clk);
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("%0d started blocks never returned a result", exp_q.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // ----------------------------------------------------------
  // compare process
  // ----------------------------------------------------------
  always @(negedge clk)
  begin
    int     exp_round;
    block_t exp_blk;
    int     exp_nr;
    if (reset_n)
    begin
      if (!ready)
      begin
        low_cnt++;
        // round 0 for one cycle, then each round for five
        exp_round = (low_cnt == 1) ? 0 : (low_cnt - 2) / 5 + 1;
        checks++;
        if (int'(round) != exp_round)
        begin
          errors++;
          $display("Mismatch at %0t: round %0d, expected %0d", $time, round, exp_round);
        end
      end
      else if (!ready_q)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("result appeared at %0t with no block started", $time);
        end
        else
        begin
          exp_blk = exp_q.pop_front();
          exp_nr  = nr_q.pop_front();
          checks += 2;
          if (new_block !== exp_blk)
          begin
            errors++;
            $display("Mismatch at %0t: new_block %h, expected %h", $time, new_block, exp_blk);
          end
          if (low_cnt != 1 + 5 * exp_nr)
          begin
            errors++;
            $display("Mismatch at %0t: busy for %0d cycles, expected %0d", $time,
                     low_cnt, 1 + 5 * exp_nr);
          end
        end
        low_cnt = 0;
      end
      ready_q = ready;
    end
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the DUT stopped finishing blocks", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

endmodule

// File: build.f
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_round_ctrl.sv
src/aes_state_datapath.sv
src/aes_encipher_block.sv
bench/tb_clock_gen.sv
bench/aes_encipher_chk.sv
bench/tb_aes_encipher.sv

// File: run.sh
#!/usr/bin/env bash
# build the aes encipher testbench with verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module tb_aes_encipher -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_aes_encipher 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
